/* filelist.f */
common/pce_pkg.sv
hw/pce_cfg_regs.sv
hw/pce_audio_mix.sv
hw/pad/pce_pad_port.sv
hw/cheat_code_loader.sv
hw/pce_io_top.sv
verif/pce_io_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the console I/O testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
SIM=pce_io_sim

verilator --binary --timing -f filelist.f --top-module pce_io_tb -o "$SIM"
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/"$SIM" > "$LOG" 2>&1
if [ $? -ne 0 ]; then
	echo "Simulation exited with an error, see $LOG"
	exit 1
fi

grep -qx "all tests passed" "$LOG"
if [ $? -ne 0 ]; then
	echo "Simulation failed, see $LOG"
	exit 1
fi

echo "Simulation passed"
exit 0

/* verif/pce_io_tb.sv */
//==========================================================================
// PC Engine console I/O testbench
// Directed tests for the option register, audio mixer, controller
// port paging, multitap stepping and cheat record assembly
//==========================================================================

module pce_io_tb;

	// Roughly four times the total length of all tests
	localparam int TIMEOUT_CYCLES = 2000;
	localparam int AUDIO_VECTORS = 20;

	logic clk_sys = 1'b0;
	logic reset;
	pce_pkg::apb_req_t apb_req;
	pce_pkg::audio_in_t audio_in;
	pce_pkg::pad_ctrl_t pad_ctrl;
	pce_pkg::pad_bank_t pads;
	logic code_wr;
	logic [3:0] code_offset;
	logic [15:0] code_data;
	pce_pkg::apb_rsp_t apb_rsp;
	pce_pkg::audio_out_t audio_out;
	logic [3:0] pad_nibble;
	pce_pkg::cheat_code_t cheat_code;
	logic code_valid;
	logic cheat_en;

	int error_count = 0;
	int check_count = 0;
	int cycle_count = 0;
	logic [31:0] rng_state = 32'd65;

	// Reference state kept by the testbench
	pce_pkg::cfg_t cfg_model;
	int pad_idx;
	logic high_page_m;
	logic prev_clr;
	logic prev_sel;
	logic [127:0] code_model;

	pce_io_top u_pce_io_top (
		.clk_sys(clk_sys),
		.reset(reset),
		.apb_req(apb_req),
		.audio_in(audio_in),
		.pad_ctrl(pad_ctrl),
		.pads(pads),
		.code_wr(code_wr),
		.code_offset(code_offset),
		.code_data(code_data),
		.apb_rsp(apb_rsp),
		.audio_out(audio_out),
		.pad_nibble(pad_nibble),
		.cheat_code(cheat_code),
		.code_valid(code_valid),
		.cheat_en(cheat_en)
	);

	always #2 clk_sys = ~clk_sys;

	always @(posedge clk_sys) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count == TIMEOUT_CYCLES) begin
			$display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Checks: %0d, errors: %0d", check_count, error_count);
			$display("tests failed");
			$finish;
		end
	end

	function automatic logic [31:0] next_rand();
		rng_state = rng_state * 32'd1664525 + 32'd1013904223;
		return rng_state;
	endfunction

	task automatic check_value(input string name, input logic [127:0] actual,
		input logic [127:0] expected);
		check_count++;
		if (actual !== expected) begin
			error_count++;
			$display("Mismatch %s: got 0x%0h, expected 0x%0h", name, actual, expected);
		end
	endtask

	//==========================================================================
	// Reference rules
	//==========================================================================
	// Sum of enabled sources scaled as (sum + sum/4) / 4 with arithmetic shifts
	function automatic pce_pkg::audio_out_t mix_expect(input pce_pkg::audio_in_t a,
		input pce_pkg::cfg_t c);
		int sl;
		int sr;
		pce_pkg::audio_out_t res;
		sl = 0;
		sr = 0;
		if (c.cdda_en) begin
			sl = sl + int'($signed(a.cdda_l));
			sr = sr + int'($signed(a.cdda_r));
		end
		if (c.psg_en) begin
			sl = sl + int'($signed(a.psg_l));
			sr = sr + int'($signed(a.psg_r));
		end
		if (c.adpcm_en) begin
			sl = sl + int'($signed(a.adpcm));
			sr = sr + int'($signed(a.adpcm));
		end
		res.left = 16'((sl + (sl >>> 2)) >>> 2);
		res.right = 16'((sr + (sr >>> 2)) >>> 2);
		return res;
	endfunction

	function automatic logic [3:0] nibble_for(input logic [11:0] btn,
		input pce_pkg::nibble_page_e page);
		logic [3:0] n;
		n = 4'h0;
		case (page)
			pce_pkg::NIB_BUTTONS: n = ~btn[7:4];
			pce_pkg::NIB_DIRS: begin
				n[0] = ~btn[pce_pkg::BTN_UP];
				n[1] = ~btn[pce_pkg::BTN_RIGHT];
				n[2] = ~btn[pce_pkg::BTN_DOWN];
				n[3] = ~btn[pce_pkg::BTN_LEFT];
			end
			pce_pkg::NIB_EXTRA: n = ~btn[11:8];
			default: n = 4'h0;
		endcase
		return n;
	endfunction

	//==========================================================================
	// Bus and port drivers
	//==========================================================================
	task automatic apb_access(input logic wr, input logic [3:0] addr,
		input logic [31:0] wdata, output logic [31:0] rdata, output logic err);
		@(posedge clk_sys);
		apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: wdata};
		@(posedge clk_sys);
		apb_req.penable <= 1'b1;
		@(negedge clk_sys);
		rdata = apb_rsp.prdata;
		err = apb_rsp.pslverr;
		check_value("pready", 128'(apb_rsp.pready), 128'(1'b1));
		// Access phase is sampled on this edge
		@(posedge clk_sys);
		apb_req <= '0;
	endtask

	task automatic set_cfg(input pce_pkg::cfg_t value);
		logic [31:0] rdata;
		logic err;
		apb_access(1'b1, pce_pkg::CFG_ADDR, 32'(value), rdata, err);
		check_value("pslverr", 128'(err), 128'(1'b0));
		cfg_model = value;
	endtask

	task automatic set_pads(input pce_pkg::pad_bank_t bank);
		@(posedge clk_sys);
		pads <= bank;
	endtask

	// Drive one pad_ctrl value, advance the model, check the settled nibble
	task automatic pad_step(input logic clr, input logic sel);
		logic [11:0] btn;
		logic [3:0] expected;
		@(posedge clk_sys);
		pad_ctrl <= '{clr: clr, sel: sel};
		if (clr) begin
			if (!prev_clr) begin
				high_page_m = ~high_page_m & cfg_model.six_button;
			end
			pad_idx = 0;
		end else if (sel && !prev_sel && cfg_model.turbo_tap) begin
			pad_idx++;
		end
		prev_clr = clr;
		prev_sel = sel;
		btn = (pad_idx < pce_pkg::NUM_PADS) ? pads[3'(pad_idx)] : 12'h000;
		expected = clr ? 4'h0 : nibble_for(btn, pce_pkg::nibble_page_e'({high_page_m, sel}));
		repeat (2) @(posedge clk_sys);
		@(negedge clk_sys);
		check_value("pad_nibble", 128'(pad_nibble), 128'(expected));
	endtask

	task automatic pad_pulse();
		pad_step(1'b1, 1'b1);
		pad_step(1'b0, 1'b1);
		pad_step(1'b0, 1'b0);
	endtask

	task automatic write_word(input logic [3:0] ofs, input logic [15:0] data);
		logic [6:0] pos;
		@(posedge clk_sys);
		code_wr <= 1'b1;
		code_offset <= ofs;
		code_data <= data;
		// Field order in the record is flags, address, compare, replace from the top
		if (!ofs[0]) begin
			pos = 7'((3 - int'(ofs >> 2)) * 32 + int'(ofs[1]) * 16);
			code_model[pos +: 16] = data;
		end
		@(posedge clk_sys);
		code_wr <= 1'b0;
		@(negedge clk_sys);
		check_value("code_valid", 128'(code_valid), 128'(ofs == 4'd14));
		check_value("cheat_code", 128'(cheat_code), code_model);
		@(posedge clk_sys);
		@(negedge clk_sys);
		check_value("code_valid", 128'(code_valid), 128'(1'b0));
	endtask

	//==========================================================================
	// Tests
	//==========================================================================
	task automatic test_reset_state();
		@(negedge clk_sys);
		check_value("audio_out", 128'(audio_out), 128'(0));
		check_value("pad_nibble", 128'(pad_nibble), 128'(0));
		check_value("code_valid", 128'(code_valid), 128'(0));
		check_value("cheat_code", 128'(cheat_code), 128'(0));
		check_value("cheat_en", 128'(cheat_en), 128'(0));
	endtask

	task automatic test_cfg_regs();
		logic [31:0] rdata;
		logic err;
		apb_access(1'b0, pce_pkg::CFG_ADDR, 32'h0, rdata, err);
		check_value("prdata", 128'(rdata), 128'(32'(pce_pkg::CFG_RESET)));
		check_value("pslverr", 128'(err), 128'(1'b0));
		// Upper data bits must be dropped
		apb_access(1'b1, pce_pkg::CFG_ADDR, 32'hFFFF_FFEA, rdata, err);
		cfg_model = pce_pkg::cfg_t'(6'h2A);
		apb_access(1'b0, pce_pkg::CFG_ADDR, 32'h0, rdata, err);
		check_value("prdata", 128'(rdata), 128'(32'h2A));
		check_value("cheat_en", 128'(cheat_en), 128'(cfg_model.cheat_en));
		apb_access(1'b1, 4'd3, 32'h15, rdata, err);
		check_value("pslverr", 128'(err), 128'(1'b1));
		apb_access(1'b0, 4'd3, 32'h0, rdata, err);
		check_value("pslverr", 128'(err), 128'(1'b1));
		apb_access(1'b0, pce_pkg::CFG_ADDR, 32'h0, rdata, err);
		check_value("prdata", 128'(rdata), 128'(32'h2A));
		set_cfg(pce_pkg::CFG_RESET);
		@(negedge clk_sys);
		check_value("cheat_en", 128'(cheat_en), 128'(1'b0));
	endtask

	task automatic test_audio_mix(input logic [2:0] en);
		pce_pkg::cfg_t value;
		pce_pkg::audio_in_t prev;
		pce_pkg::audio_in_t bundle;
		value = cfg_model;
		{value.psg_en, value.cdda_en, value.adpcm_en} = en;
		set_cfg(value);
		prev = audio_in;
		for (int i = 0; i < AUDIO_VECTORS; i++) begin
			bundle.cdda_l = 16'(next_rand() >> 16);
			bundle.cdda_r = 16'(next_rand() >> 16);
			bundle.psg_l = 16'(next_rand() >> 16);
			bundle.psg_r = 16'(next_rand() >> 16);
			bundle.adpcm = 16'(next_rand() >> 16);
			@(posedge clk_sys);
			audio_in <= bundle;
			// Output still holds the previous bundle one cycle in
			@(posedge clk_sys);
			@(negedge clk_sys);
			check_value("audio_out", 128'(audio_out), 128'(mix_expect(prev, cfg_model)));
			@(posedge clk_sys);
			@(negedge clk_sys);
			check_value("audio_out", 128'(audio_out), 128'(mix_expect(bundle, cfg_model)));
			prev = bundle;
		end
	endtask

	task automatic test_single_pad();
		pce_pkg::pad_bank_t bank;
		pce_pkg::cfg_t value;
		value = cfg_model;
		value.turbo_tap = 1'b0;
		value.six_button = 1'b0;
		set_cfg(value);
		repeat (3) begin
			for (int i = 0; i < pce_pkg::NUM_PADS; i++) begin
				bank[i] = 12'(next_rand() >> 16);
			end
			set_pads(bank);
			pad_pulse();
			pad_step(1'b0, 1'b1);
			pad_step(1'b0, 1'b0);
		end
	endtask

	task automatic test_six_button();
		pce_pkg::pad_bank_t bank;
		pce_pkg::cfg_t value;
		value = cfg_model;
		value.six_button = 1'b1;
		set_cfg(value);
		for (int i = 0; i < pce_pkg::NUM_PADS; i++) begin
			bank[i] = 12'(next_rand() >> 16);
		end
		set_pads(bank);
		repeat (3) pad_pulse();
		// Normal pads stay on the low pages
		value.six_button = 1'b0;
		set_cfg(value);
		repeat (2) pad_pulse();
	endtask

	task automatic test_turbo_tap();
		pce_pkg::pad_bank_t bank;
		pce_pkg::cfg_t value;
		logic [11:0] base;
		value = cfg_model;
		value.turbo_tap = 1'b1;
		set_cfg(value);
		base = 12'(next_rand() >> 16);
		for (int i = 0; i < pce_pkg::NUM_PADS; i++) begin
			bank[i] = base ^ {3{4'(i)}};
		end
		set_pads(bank);
		pad_pulse();
		// Last step goes past pad 4
		for (int i = 1; i <= pce_pkg::NUM_PADS; i++) begin
			pad_step(1'b0, 1'b1);
			pad_step(1'b0, 1'b0);
		end
	endtask

	task automatic test_cheat_loader();
		logic [3:0] order [8];
		order = '{4'd6, 4'd0, 4'd12, 4'd2, 4'd14, 4'd10, 4'd4, 4'd8};
		foreach (order[k]) begin
			write_word(order[k], 16'(next_rand() >> 16));
		end
		write_word(4'd5, 16'hDEAD);
		// Partial update without the closing word
		write_word(4'd4, 16'(next_rand() >> 16));
		write_word(4'd10, 16'(next_rand() >> 16));
	endtask

	initial begin
		reset = 1'b1;
		apb_req = '0;
		audio_in = '0;
		pad_ctrl = '0;
		pads = '0;
		code_wr = 1'b0;
		code_offset = 4'h0;
		code_data = 16'h0;
		cfg_model = pce_pkg::CFG_RESET;
		pad_idx = 0;
		high_page_m = 1'b0;
		prev_clr = 1'b0;
		prev_sel = 1'b0;
		code_model = '0;
		repeat (8) @(posedge clk_sys);
		reset <= 1'b0;
		test_reset_state();
		test_cfg_regs();
		test_audio_mix(3'b111);
		test_audio_mix(3'b101);
		test_audio_mix(3'b010);
		test_audio_mix(3'b000);
		test_single_pad();
		test_six_button();
		test_turbo_tap();
		test_cheat_loader();
		$display("Checks: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

/* hw/pce_io_top.sv */
//==========================================================================
// PC Engine console I/O top level
// Configuration register, audio mixer, controller port and cheat
// record assembler, with the option bits fanned out to each block
//==========================================================================

module pce_io_top (
	input logic clk_sys,
	input logic reset,
	input pce_pkg::apb_req_t apb_req,
	input pce_pkg::audio_in_t audio_in,
	input pce_pkg::pad_ctrl_t pad_ctrl,
	input pce_pkg::pad_bank_t pads,
	input logic code_wr,
	input logic [3:0] code_offset,
	input logic [15:0] code_data,
	output pce_pkg::apb_rsp_t apb_rsp,
	output pce_pkg::audio_out_t audio_out,
	output logic [3:0] pad_nibble,
	output pce_pkg::cheat_code_t cheat_code,
	output logic code_valid,
	output logic cheat_en
);

	pce_pkg::cfg_t cfg;

	// Cheat enable is consumed outside this block
	assign cheat_en = cfg.cheat_en;

	pce_cfg_regs u_cfg_regs (
		.clk_sys(clk_sys),
		.reset(reset),
		.apb_req(apb_req),
		.apb_rsp(apb_rsp),
		.cfg(cfg)
	);

	pce_audio_mix u_audio_mix (
		.clk_sys(clk_sys),
		.reset(reset),
		.audio_in(audio_in),
		.psg_en(cfg.psg_en),
		.cdda_en(cfg.cdda_en),
		.adpcm_en(cfg.adpcm_en),
		.audio_out(audio_out)
	);

	pce_pad_port u_pad_port (
		.clk_sys(clk_sys),
		.reset(reset),
		.pad_ctrl(pad_ctrl),
		.pads(pads),
		.turbo_tap(cfg.turbo_tap),
		.six_button(cfg.six_button),
		.pad_nibble(pad_nibble)
	);

	cheat_code_loader u_cheat_loader (
		.clk_sys(clk_sys),
		.reset(reset),
		.code_wr(code_wr),
		.code_offset(code_offset),
		.code_data(code_data),
		.cheat_code(cheat_code),
		.code_valid(code_valid)
	);

endmodule

/* hw/cheat_code_loader.sv */
//==========================================================================
// Cheat code assembler
// Collects eight 16-bit words by byte offset into one code record
// and flags the record complete after the last word
//==========================================================================

module cheat_code_loader (
	input logic clk_sys,
	input logic reset,
	input logic code_wr,
	input logic [3:0] code_offset,
	input logic [15:0] code_data,
	output pce_pkg::cheat_code_t cheat_code,
	output logic code_valid
);

	localparam logic [3:0] LAST_OFS = 4'(pce_pkg::CODE_LAST_OFS);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cheat_code <= '0;
			code_valid <= 1'b0;
		end else begin
			// One-cycle strobe
			code_valid <= 1'b0;

			if (code_wr) begin
				// Low word first in each pair, odd offsets fall through
				case (code_offset)
					4'd0: cheat_code.flags[15:0] <= code_data;
					4'd2: cheat_code.flags[31:16] <= code_data;
					4'd4: cheat_code.address[15:0] <= code_data;
					4'd6: cheat_code.address[31:16] <= code_data;
					4'd8: cheat_code.compare[15:0] <= code_data;
					4'd10: cheat_code.compare[31:16] <= code_data;
					4'd12: cheat_code.replace[15:0] <= code_data;
					LAST_OFS: begin
						cheat_code.replace[31:16] <= code_data;
						// Last word closes the record
						code_valid <= 1'b1;
					end
					default: begin
					end
				endcase
			end
		end
	end

endmodule

/* hw/pad/pce_pad_port.sv */
//==========================================================================
// Controller port
// Multitap pad select, six-button page toggle and the registered
// active-low nibble returned to the console
//==========================================================================

module pce_pad_port (
	input logic clk_sys,
	input logic reset,
	input pce_pkg::pad_ctrl_t pad_ctrl,
	input pce_pkg::pad_bank_t pads,
	input logic turbo_tap,
	input logic six_button,
	output logic [3:0] pad_nibble
);

	pce_pkg::pad_ctrl_t ctrl_q;
	logic [2:0] port_idx;
	logic high_page;
	logic pad_present;
	logic [pce_pkg::PAD_BTN_W-1:0] btn;
	pce_pkg::nibble_page_e page;
	logic [3:0] page_nibble;
	logic clr_rise;
	logic sel_rise;

	assign clr_rise = pad_ctrl.clr & ~ctrl_q.clr;
	assign sel_rise = pad_ctrl.sel & ~ctrl_q.sel;

	//==========================================================================
	// Page selection
	//==========================================================================
	// Indexes past the last pad see no buttons, so the low pages read F
	assign pad_present = (int'(port_idx) < pce_pkg::NUM_PADS);
	assign btn = pad_present ? pads[port_idx] : '0;

	assign page = pce_pkg::nibble_page_e'({high_page, pad_ctrl.sel});

	always_comb begin
		case (page)
			pce_pkg::NIB_BUTTONS: begin
				page_nibble = ~btn[pce_pkg::BTN_I +: 4];
			end
			pce_pkg::NIB_DIRS: begin
				// Console order is up, right, down, left from bit 0
				page_nibble = ~{btn[pce_pkg::BTN_LEFT], btn[pce_pkg::BTN_DOWN],
					btn[pce_pkg::BTN_RIGHT], btn[pce_pkg::BTN_UP]};
			end
			pce_pkg::NIB_EXTRA: begin
				page_nibble = ~btn[pce_pkg::BTN_III +: 4];
			end
			default: begin
				// Six-button pad ID page
				page_nibble = 4'h0;
			end
		endcase
	end

	//==========================================================================
	// Port index, page flag and nibble latch
	//==========================================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			ctrl_q <= '0;
			port_idx <= '0;
			high_page <= 1'b0;
			pad_nibble <= 4'h0;
		end else begin
			ctrl_q <= pad_ctrl;
			pad_nibble <= page_nibble;

			if (pad_ctrl.clr) begin
				port_idx <= '0;
				pad_nibble <= 4'h0;
				// Each clr pulse flips the page, only for six-button pads
				if (clr_rise) begin
					high_page <= ~high_page & six_button;
				end
			end else if (sel_rise && turbo_tap) begin
				port_idx <= port_idx + 3'd1;
			end
		end
	end

endmodule

/* hw/pce_audio_mix.sv */
//==========================================================================
// Stereo audio mixer
// Sums CD-audio, PSG and ADPCM with per-source enables, then applies
// a gain of 1.25 and keeps the top 16 bits, two cycles of latency
//==========================================================================

module pce_audio_mix (
	input logic clk_sys,
	input logic reset,
	input pce_pkg::audio_in_t audio_in,
	input logic psg_en,
	input logic cdda_en,
	input logic adpcm_en,
	output pce_pkg::audio_out_t audio_out
);

	localparam int EXT_W = pce_pkg::MIX_W - pce_pkg::SAMPLE_W;

	logic signed [pce_pkg::MIX_W-1:0] sum_l;
	logic signed [pce_pkg::MIX_W-1:0] sum_r;
	logic signed [pce_pkg::MIX_W-1:0] mix_l;
	logic signed [pce_pkg::MIX_W-1:0] mix_r;

	// Sign-extend one source, zero when disabled
	function automatic logic signed [pce_pkg::MIX_W-1:0] src_term(
		input logic en,
		input logic signed [pce_pkg::SAMPLE_W-1:0] sample
	);
		return en ? {{EXT_W{sample[pce_pkg::SAMPLE_W-1]}}, sample} : '0;
	endfunction

	// Stage 1 per-channel sum, ADPCM goes to both sides
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			sum_l <= '0;
			sum_r <= '0;
		end else begin
			sum_l <= src_term(cdda_en, audio_in.cdda_l) + src_term(psg_en, audio_in.psg_l)
				+ src_term(adpcm_en, audio_in.adpcm);
			sum_r <= src_term(cdda_en, audio_in.cdda_r) + src_term(psg_en, audio_in.psg_r)
				+ src_term(adpcm_en, audio_in.adpcm);
		end
	end

	// Stage 2 adds a quarter, so full scale of three sources still fits
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			mix_l <= '0;
			mix_r <= '0;
		end else begin
			mix_l <= sum_l + (sum_l >>> 2);
			mix_r <= sum_r + (sum_r >>> 2);
		end
	end

	assign audio_out.left = mix_l[pce_pkg::MIX_W-1 -: pce_pkg::SAMPLE_W];
	assign audio_out.right = mix_r[pce_pkg::MIX_W-1 -: pce_pkg::SAMPLE_W];

endmodule

/* hw/pce_cfg_regs.sv */
//==========================================================================
// Console option register
// APB slave with one 6-bit configuration word, zero wait states
//==========================================================================

module pce_cfg_regs (
	input logic clk_sys,
	input logic reset,
	input pce_pkg::apb_req_t apb_req,
	output pce_pkg::apb_rsp_t apb_rsp,
	output pce_pkg::cfg_t cfg
);

	localparam int CFG_W = $bits(pce_pkg::cfg_t);

	logic access;
	logic addr_hit;
	logic wr_en;

	// Access phase of an APB transfer
	assign access = apb_req.psel & apb_req.penable;
	assign addr_hit = (apb_req.paddr == pce_pkg::CFG_ADDR);
	// Writes to unmapped addresses are dropped
	assign wr_en = access & apb_req.pwrite & addr_hit;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cfg <= pce_pkg::CFG_RESET;
		end else if (wr_en) begin
			cfg <= pce_pkg::cfg_t'(apb_req.pwdata[CFG_W-1:0]);
		end
	end

	//==========================================================================
	// Response
	//==========================================================================
	always_comb begin
		apb_rsp.pready = 1'b1;
		apb_rsp.pslverr = access & ~addr_hit;
		// Zero-extended option word, nothing else readable
		if (addr_hit) begin
			apb_rsp.prdata = 32'(cfg);
		end else begin
			apb_rsp.prdata = '0;
		end
	end

endmodule

/* common/pce_pkg.sv */
//==========================================================================
// PC Engine console I/O shared definitions
// Sample widths, pad and cheat geometry, configuration word layout,
// APB request and response bundles and the pad nibble page encoding
//==========================================================================

package pce_pkg;

	// Audio widths
	localparam int SAMPLE_W = 16;
	// Two guard bits cover three summed sources plus the 1/4 term
	localparam int MIX_W = 18;

	// Multitap geometry
	localparam int NUM_PADS = 5;
	localparam int PAD_BTN_W = 12;

	// Button bit positions inside one pad word
	localparam int BTN_RIGHT = 0;
	localparam int BTN_LEFT = 1;
	localparam int BTN_DOWN = 2;
	localparam int BTN_UP = 3;
	// I, II, Select, Run start here
	localparam int BTN_I = 4;
	// III to VI start here
	localparam int BTN_III = 8;

	// Cheat record made of 16-bit words at even byte offsets
	localparam int CODE_WORDS = 8;
	localparam int CODE_LAST_OFS = 2 * (CODE_WORDS - 1);

	// Single configuration register on the APB
	localparam logic [3:0] CFG_ADDR = 4'd0;

	//==========================================================================
	// Configuration word
	//==========================================================================
	typedef struct packed {
		logic turbo_tap;
		logic six_button;
		logic cheat_en;
		logic psg_en;
		logic cdda_en;
		logic adpcm_en;
	} cfg_t;

	// All audio sources on, everything else off
	localparam cfg_t CFG_RESET = '{
		turbo_tap: 1'b0,
		six_button: 1'b0,
		cheat_en: 1'b0,
		psg_en: 1'b1,
		cdda_en: 1'b1,
		adpcm_en: 1'b1
	};

	//==========================================================================
	// APB bundles
	//==========================================================================
	typedef struct packed {
		logic psel;
		logic penable;
		logic pwrite;
		logic [3:0] paddr;
		logic [31:0] pwdata;
	} apb_req_t;

	typedef struct packed {
		logic [31:0] prdata;
		logic pready;
		logic pslverr;
	} apb_rsp_t;

	//==========================================================================
	// Audio, pad and cheat payloads
	//==========================================================================
	typedef struct packed {
		logic signed [SAMPLE_W-1:0] cdda_l;
		logic signed [SAMPLE_W-1:0] cdda_r;
		logic signed [SAMPLE_W-1:0] psg_l;
		logic signed [SAMPLE_W-1:0] psg_r;
		// Mono source, feeds both channels
		logic signed [SAMPLE_W-1:0] adpcm;
	} audio_in_t;

	typedef struct packed {
		logic signed [SAMPLE_W-1:0] left;
		logic signed [SAMPLE_W-1:0] right;
	} audio_out_t;

	// Bit 0 is sel and bit 1 is clr, as the console drives them
	typedef struct packed {
		logic clr;
		logic sel;
	} pad_ctrl_t;

	// One word per pad, 1 means pressed
	typedef logic [NUM_PADS-1:0][PAD_BTN_W-1:0] pad_bank_t;

	typedef struct packed {
		logic [31:0] flags;
		logic [31:0] address;
		logic [31:0] compare;
		logic [31:0] replace;
	} cheat_code_t;

	// Encoded as {high page, sel}
	typedef enum logic [1:0] {
		NIB_BUTTONS = 2'd0,
		NIB_DIRS = 2'd1,
		NIB_EXTRA = 2'd2,
		NIB_NONE = 2'd3
	} nibble_page_e;

endpackage
